/* design/pb_pkg.sv */
package pb_pkg;

    // ====================
    // Sizes
    // ====================
    localparam int data_byte_wid = 8;
    localparam int data_wid      = data_byte_wid * 8;
    localparam int mem_depth     = 512;
    localparam int mem_addr_wid  = $clog2(mem_depth);

    // Per-packet metadata, carried on every beat
    localparam int tid_wid   = 8;
    localparam int tdest_wid = 12;
    localparam int tuser_wid = 32;
    localparam int meta_wid  = tid_wid + tdest_wid + tuser_wid;

    // Packet length in bytes
    localparam int len_wid = 11;

    // ====================
    // Register map
    // ====================
    localparam int reg_addr_wid = 3;
    localparam int reg_data_wid = 32;

    localparam logic [reg_addr_wid-1:0] reg_info_mem_size = 3'd0;
    localparam logic [reg_addr_wid-1:0] reg_info_meta_wid = 3'd1;
    // Ready [0], busy [1], done [2]
    localparam logic [reg_addr_wid-1:0] reg_status        = 3'd2;
    // Enable [0], start pulse [1], clear done [2]
    localparam logic [reg_addr_wid-1:0] reg_control       = 3'd3;
    localparam logic [reg_addr_wid-1:0] reg_wr_addr       = 3'd4;
    localparam logic [reg_addr_wid-1:0] reg_wr_data_lo    = 3'd5;
    // Write commits the word
    localparam logic [reg_addr_wid-1:0] reg_wr_data_hi    = 3'd6;
    localparam logic [reg_addr_wid-1:0] reg_pkt_addr      = 3'd7;

    // Playback engine states
    localparam logic [1:0] eng_idle  = 2'd0;
    localparam logic [1:0] eng_desc  = 2'd1;
    localparam logic [1:0] eng_beats = 2'd2;

    // ====================
    // Memory word
    // ====================
    // Descriptor or data beat, same 64 bits
    typedef union packed {
        struct packed {
            logic [data_wid-len_wid-meta_wid-1:0] pad;
            logic [len_wid-1:0]                   len;
            logic [tid_wid-1:0]                   tid;
            logic [tdest_wid-1:0]                 tdest;
            logic [tuser_wid-1:0]                 tuser;
        } desc;
        // Lane 0 is the top byte
        logic [0:data_byte_wid-1][7:0] beat;
    } mem_word_u;

endpackage

/* design/pb_packet_mem.sv */
module pb_packet_mem (
    input  logic                            clk,
    input  logic                            we,
    input  logic [pb_pkg::mem_addr_wid-1:0] addr,
    input  logic [pb_pkg::data_wid-1:0]     wdata,
    output logic [pb_pkg::data_wid-1:0]     rdata
);

    // Packet storage
    logic [pb_pkg::data_wid-1:0] mem [pb_pkg::mem_depth];

    // Single port, read data one cycle after address
    always_ff @(posedge clk)
    begin
        if (we)
        begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

/* design/pb_mem_arbiter.sv */
module pb_mem_arbiter (
    input  logic                            clk,
    input  logic                            arst_n,
    // Register block, writes only
    input  logic                            reg_req,
    input  logic                            reg_we,
    input  logic [pb_pkg::mem_addr_wid-1:0] reg_addr,
    input  logic [pb_pkg::data_wid-1:0]     reg_wdata,
    output logic                            reg_gnt,
    // Playback engine, reads only
    input  logic                            eng_req,
    input  logic [pb_pkg::mem_addr_wid-1:0] eng_addr,
    output logic                            eng_gnt,
    output logic                            eng_rvalid,
    output logic [pb_pkg::data_wid-1:0]     mem_rdata_out,
    // Packet memory port
    output logic                            mem_we,
    output logic [pb_pkg::mem_addr_wid-1:0] mem_addr,
    output logic [pb_pkg::data_wid-1:0]     mem_wdata,
    input  logic [pb_pkg::data_wid-1:0]     mem_rdata
);

    // Engine read issued last cycle
    logic eng_rd_q;

    // Fixed priority, register block first
    assign reg_gnt = reg_req;
    assign eng_gnt = eng_req && !reg_req;

    // Forward the winner
    assign mem_we    = reg_gnt && reg_we;
    assign mem_addr  = reg_gnt ? reg_addr : eng_addr;
    assign mem_wdata = reg_wdata;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            eng_rd_q <= 1'b0;
        end
        else
        begin
            eng_rd_q <= eng_gnt;
        end
    end

    // Read data lines up with the marker
    assign eng_rvalid    = eng_rd_q;
    assign mem_rdata_out = mem_rdata;

    // One owner of the port per cycle
    a_one_grant: assert property (@(posedge clk) disable iff (!arst_n)
        !(reg_gnt && eng_gnt));

endmodule

/* design/pb_reg_block.sv */
module pb_reg_block (
    input  logic                            clk,
    input  logic                            arst_n,
    // Host register port
    input  logic                            reg_wr,
    input  logic                            reg_rd,
    input  logic [pb_pkg::reg_addr_wid-1:0] reg_addr,
    input  logic [pb_pkg::reg_data_wid-1:0] reg_wdata,
    output logic [pb_pkg::reg_data_wid-1:0] reg_rdata,
    output logic                            reg_rvalid,
    // Memory requester
    output logic                            mem_req,
    output logic                            mem_we,
    output logic [pb_pkg::mem_addr_wid-1:0] mem_addr,
    output logic [pb_pkg::data_wid-1:0]     mem_wdata,
    input  logic                            mem_gnt,
    // Playback control
    output logic                            start,
    output logic [pb_pkg::mem_addr_wid-1:0] start_addr,
    input  logic                            busy,
    input  logic                            done_pulse
);

    logic                            ready;
    logic [pb_pkg::mem_addr_wid-1:0] clr_addr;
    logic                            enable;
    logic                            done;
    logic [pb_pkg::mem_addr_wid-1:0] wr_addr;
    logic [pb_pkg::mem_addr_wid-1:0] pkt_addr;
    logic [pb_pkg::reg_data_wid-1:0] wdata_lo;
    logic                            pend;
    logic [pb_pkg::mem_addr_wid-1:0] pend_addr;
    logic [pb_pkg::data_wid-1:0]     pend_data;
    logic                            wr_ctrl;
    logic                            commit;

    assign wr_ctrl = reg_wr && (reg_addr == pb_pkg::reg_control);
    // High half write commits only once the clear is done
    assign commit  = reg_wr && (reg_addr == pb_pkg::reg_wr_data_hi) && ready;

    // ====================
    // Clear sweep
    // ====================
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            clr_addr <= '0;
            ready    <= 1'b0;
        end
        else if (!ready && mem_gnt)
        begin
            clr_addr <= clr_addr + 1'b1;
            // Last word zeroed
            if (clr_addr == pb_pkg::mem_addr_wid'(pb_pkg::mem_depth - 1))
            begin
                ready <= 1'b1;
            end
        end
    end

    // ====================
    // Control registers
    // ====================
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            enable   <= 1'b0;
            done     <= 1'b0;
            start    <= 1'b0;
            pend     <= 1'b0;
            wr_addr  <= '0;
            pkt_addr <= '0;
        end
        else
        begin
            pend  <= commit || (pend && !mem_gnt);
            // Start needs enable in the same write
            start <= wr_ctrl && reg_wdata[1] && reg_wdata[0] && ready;
            if (wr_ctrl)
            begin
                enable <= reg_wdata[0];
            end
            // Sticky until host clears it
            if (done_pulse)
            begin
                done <= 1'b1;
            end
            else if (wr_ctrl && reg_wdata[2])
            begin
                done <= 1'b0;
            end
            if (reg_wr && (reg_addr == pb_pkg::reg_wr_addr))
            begin
                wr_addr <= reg_wdata[pb_pkg::mem_addr_wid-1:0];
            end
            else if (commit)
            begin
                wr_addr <= wr_addr + 1'b1;
            end
            if (reg_wr && (reg_addr == pb_pkg::reg_pkt_addr))
            begin
                pkt_addr <= reg_wdata[pb_pkg::mem_addr_wid-1:0];
            end
        end
    end

    // Word assembly
    always_ff @(posedge clk)
    begin
        if (reg_wr && (reg_addr == pb_pkg::reg_wr_data_lo))
        begin
            wdata_lo <= reg_wdata;
        end
        if (commit)
        begin
            pend_data <= {reg_wdata, wdata_lo};
            pend_addr <= wr_addr;
        end
    end

    // Sweep writes zeros until ready
    // Then the committed word
    assign mem_req    = !ready || pend;
    assign mem_we     = mem_req;
    assign mem_addr   = ready ? pend_addr : clr_addr;
    assign mem_wdata  = ready ? pend_data : '0;
    assign start_addr = pkt_addr;

    // ====================
    // Register reads
    // ====================
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            reg_rvalid <= 1'b0;
        end
        else
        begin
            reg_rvalid <= reg_rd;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reg_rd)
        begin
            case (reg_addr)
                pb_pkg::reg_info_mem_size:
                    reg_rdata <= pb_pkg::reg_data_wid'(pb_pkg::mem_depth);
                pb_pkg::reg_info_meta_wid:
                    reg_rdata <= pb_pkg::reg_data_wid'(pb_pkg::meta_wid);
                // Busy covers the start cycle too
                pb_pkg::reg_status:
                    reg_rdata <= pb_pkg::reg_data_wid'({done, busy || start, ready});
                pb_pkg::reg_control:
                    reg_rdata <= pb_pkg::reg_data_wid'(enable);
                pb_pkg::reg_wr_addr:
                    reg_rdata <= pb_pkg::reg_data_wid'(wr_addr);
                pb_pkg::reg_wr_data_lo:
                    reg_rdata <= wdata_lo;
                pb_pkg::reg_wr_data_hi:
                    reg_rdata <= pend_data[pb_pkg::data_wid-1:pb_pkg::reg_data_wid];
                default:
                    reg_rdata <= pb_pkg::reg_data_wid'(pkt_addr);
            endcase
        end
    end

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!arst_n)
        !(reg_wr && reg_rd));

endmodule

/* design/pb_playback_engine.sv */
module pb_playback_engine (
    input  logic                             clk,
    input  logic                             arst_n,
    // From the register block
    input  logic                             start,
    input  logic [pb_pkg::mem_addr_wid-1:0]  start_addr,
    output logic                             busy,
    output logic                             done_pulse,
    // Memory reads
    output logic                             mem_req,
    output logic [pb_pkg::mem_addr_wid-1:0]  mem_addr,
    input  logic                             mem_gnt,
    input  logic                             mem_rvalid,
    input  logic [pb_pkg::data_wid-1:0]      mem_rdata,
    // AXI4-Stream out
    output logic                             axis_tvalid,
    input  logic                             axis_tready,
    output logic [pb_pkg::data_wid-1:0]      axis_tdata,
    output logic [pb_pkg::data_byte_wid-1:0] axis_tkeep,
    output logic                             axis_tlast,
    output logic [pb_pkg::tid_wid-1:0]       axis_tid,
    output logic [pb_pkg::tdest_wid-1:0]     axis_tdest,
    output logic [pb_pkg::tuser_wid-1:0]     axis_tuser
);

    logic [1:0]                       state;
    logic                             desc_issued;
    // Beats left to issue, bytes left to receive
    logic [pb_pkg::len_wid-1:0]       beats_left;
    logic [pb_pkg::len_wid-1:0]       rx_left;
    logic [1:0]                       in_flight;
    logic                             room;
    pb_pkg::mem_word_u                word;
    logic                             rx_desc;
    logic                             rx_beat;
    logic                             beat_last;
    logic [pb_pkg::data_byte_wid-1:0] beat_keep;
    logic [pb_pkg::data_wid-1:0]      beat_data;
    logic [pb_pkg::meta_wid-1:0]      cur_meta;
    // Two-entry output buffer
    logic [pb_pkg::data_wid-1:0]      buf_data [2];
    logic [pb_pkg::data_byte_wid-1:0] buf_keep [2];
    logic                             buf_last [2];
    logic [pb_pkg::meta_wid-1:0]      buf_meta [2];
    logic [1:0]                       buf_cnt;
    logic                             wr_ptr;
    logic                             rd_ptr;
    logic                             pop;

    // ====================
    // Read issue
    // ====================
    // Buffer must hold every outstanding read
    assign room     = ({1'b0, buf_cnt} + {1'b0, in_flight}) < 3'd2;
    assign mem_req  = room && ((state == pb_pkg::eng_beats) ||
                               ((state == pb_pkg::eng_desc) && !desc_issued));
    assign busy     = state != pb_pkg::eng_idle;

    // Returns come in order, so an empty byte count means descriptor
    assign word    = mem_rdata;
    assign rx_desc = mem_rvalid && (rx_left == '0);
    assign rx_beat = mem_rvalid && (rx_left != '0);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state       <= pb_pkg::eng_idle;
            desc_issued <= 1'b0;
            mem_addr    <= '0;
            beats_left  <= '0;
            rx_left     <= '0;
            done_pulse  <= 1'b0;
        end
        else
        begin
            done_pulse <= 1'b0;
            if (mem_gnt)
            begin
                mem_addr <= mem_addr + 1'b1;
            end
            if (rx_beat)
            begin
                rx_left <= beat_last ? '0 : rx_left - pb_pkg::len_wid'(pb_pkg::data_byte_wid);
            end
            case (state)
                pb_pkg::eng_idle:
                    if (start)
                    begin
                        mem_addr    <= start_addr;
                        desc_issued <= 1'b0;
                        state       <= pb_pkg::eng_desc;
                    end
                pb_pkg::eng_desc:
                begin
                    if (mem_gnt)
                    begin
                        desc_issued <= 1'b1;
                    end
                    // Length zero ends the list
                    if (rx_desc && (word.desc.len == '0))
                    begin
                        state      <= pb_pkg::eng_idle;
                        done_pulse <= 1'b1;
                    end
                    else if (rx_desc)
                    begin
                        rx_left    <= word.desc.len;
                        beats_left <= (word.desc.len >> 3) +
                                      pb_pkg::len_wid'(word.desc.len[2:0] != 3'd0);
                        state      <= pb_pkg::eng_beats;
                    end
                end
                default:
                    if (mem_gnt)
                    begin
                        beats_left <= beats_left - 1'b1;
                        // Next descriptor sits right after the last beat
                        if (beats_left == pb_pkg::len_wid'(1))
                        begin
                            state       <= pb_pkg::eng_desc;
                            desc_issued <= 1'b0;
                        end
                    end
            endcase
        end
    end

    // ====================
    // Beat shaping
    // ====================
    assign beat_last = rx_left <= pb_pkg::len_wid'(pb_pkg::data_byte_wid);
    // Partial last beat fills lanes from the top
    assign beat_keep = (beat_last && (rx_left[2:0] != 3'd0)) ?
                       ~({pb_pkg::data_byte_wid{1'b1}} >> rx_left[2:0]) : '1;

    // Unused lanes forced to zero
    always_comb
    begin
        for (int i = 0; i < pb_pkg::data_byte_wid; i++)
        begin
            beat_data[pb_pkg::data_wid-1-8*i -: 8] =
                beat_keep[pb_pkg::data_byte_wid-1-i] ? word.beat[i] : 8'h00;
        end
    end

    // ====================
    // Output buffer
    // ====================
    assign pop = axis_tvalid && axis_tready;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            in_flight <= '0;
            buf_cnt   <= '0;
            wr_ptr    <= 1'b0;
            rd_ptr    <= 1'b0;
        end
        else
        begin
            in_flight <= in_flight + 2'(mem_gnt) - 2'(mem_rvalid);
            buf_cnt   <= buf_cnt + 2'(rx_beat) - 2'(pop);
            wr_ptr    <= wr_ptr ^ rx_beat;
            rd_ptr    <= rd_ptr ^ pop;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rx_desc)
        begin
            cur_meta <= {word.desc.tid, word.desc.tdest, word.desc.tuser};
        end
        if (rx_beat)
        begin
            buf_data[wr_ptr] <= beat_data;
            buf_keep[wr_ptr] <= beat_keep;
            buf_last[wr_ptr] <= beat_last;
            buf_meta[wr_ptr] <= cur_meta;
        end
    end

    // Head entry drives the stream
    assign axis_tvalid = buf_cnt != 2'd0;
    assign axis_tdata  = buf_data[rd_ptr];
    assign axis_tkeep  = buf_keep[rd_ptr];
    assign axis_tlast  = buf_last[rd_ptr];
    assign {axis_tid, axis_tdest, axis_tuser} = buf_meta[rd_ptr];

    a_axis_hold: assert property (@(posedge clk) disable iff (!arst_n)
        axis_tvalid && !axis_tready |=> axis_tvalid && $stable(axis_tdata) &&
        $stable(axis_tkeep) && $stable(axis_tlast) && $stable(axis_tid) &&
        $stable(axis_tdest) && $stable(axis_tuser));

endmodule

/* design/pb_top.sv */
module pb_top (
    input  logic                             clk,
    input  logic                             arst_n,
    // Host register port
    input  logic                             reg_wr,
    input  logic                             reg_rd,
    input  logic [pb_pkg::reg_addr_wid-1:0]  reg_addr,
    input  logic [pb_pkg::reg_data_wid-1:0]  reg_wdata,
    output logic [pb_pkg::reg_data_wid-1:0]  reg_rdata,
    output logic                             reg_rvalid,
    // AXI4-Stream out
    output logic                             axis_tvalid,
    input  logic                             axis_tready,
    output logic [pb_pkg::data_wid-1:0]      axis_tdata,
    output logic [pb_pkg::data_byte_wid-1:0] axis_tkeep,
    output logic                             axis_tlast,
    output logic [pb_pkg::tid_wid-1:0]       axis_tid,
    output logic [pb_pkg::tdest_wid-1:0]     axis_tdest,
    output logic [pb_pkg::tuser_wid-1:0]     axis_tuser
);

    // Register block to arbiter
    logic                            rb_req;
    logic                            rb_we;
    logic [pb_pkg::mem_addr_wid-1:0] rb_addr;
    logic [pb_pkg::data_wid-1:0]     rb_wdata;
    logic                            rb_gnt;
    // Engine to arbiter
    logic                            eng_req;
    logic [pb_pkg::mem_addr_wid-1:0] eng_addr;
    logic                            eng_gnt;
    logic                            eng_rvalid;
    logic [pb_pkg::data_wid-1:0]     eng_rdata;
    // Arbiter to memory
    logic                            mem_we;
    logic [pb_pkg::mem_addr_wid-1:0] mem_addr;
    logic [pb_pkg::data_wid-1:0]     mem_wdata;
    logic [pb_pkg::data_wid-1:0]     mem_rdata;
    // Playback control
    logic                            start;
    logic [pb_pkg::mem_addr_wid-1:0] start_addr;
    logic                            busy;
    logic                            done_pulse;

    pb_reg_block u_reg_block (
        .clk        (clk),
        .arst_n     (arst_n),
        .reg_wr     (reg_wr),
        .reg_rd     (reg_rd),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata),
        .reg_rvalid (reg_rvalid),
        .mem_req    (rb_req),
        .mem_we     (rb_we),
        .mem_addr   (rb_addr),
        .mem_wdata  (rb_wdata),
        .mem_gnt    (rb_gnt),
        .start      (start),
        .start_addr (start_addr),
        .busy       (busy),
        .done_pulse (done_pulse)
    );

    pb_playback_engine u_engine (
        .clk         (clk),
        .arst_n      (arst_n),
        .start       (start),
        .start_addr  (start_addr),
        .busy        (busy),
        .done_pulse  (done_pulse),
        .mem_req     (eng_req),
        .mem_addr    (eng_addr),
        .mem_gnt     (eng_gnt),
        .mem_rvalid  (eng_rvalid),
        .mem_rdata   (eng_rdata),
        .axis_tvalid (axis_tvalid),
        .axis_tready (axis_tready),
        .axis_tdata  (axis_tdata),
        .axis_tkeep  (axis_tkeep),
        .axis_tlast  (axis_tlast),
        .axis_tid    (axis_tid),
        .axis_tdest  (axis_tdest),
        .axis_tuser  (axis_tuser)
    );

    pb_mem_arbiter u_arbiter (
        .clk           (clk),
        .arst_n        (arst_n),
        .reg_req       (rb_req),
        .reg_we        (rb_we),
        .reg_addr      (rb_addr),
        .reg_wdata     (rb_wdata),
        .reg_gnt       (rb_gnt),
        .eng_req       (eng_req),
        .eng_addr      (eng_addr),
        .eng_gnt       (eng_gnt),
        .eng_rvalid    (eng_rvalid),
        .mem_rdata_out (eng_rdata),
        .mem_we        (mem_we),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .mem_rdata     (mem_rdata)
    );

    pb_packet_mem u_packet_mem (
        .clk   (clk),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

endmodule

/* include/pb_tb_model.svh */
`ifndef PB_TB_MODEL_SVH
`define PB_TB_MODEL_SVH

// 16-bit Fibonacci LFSR, taps 16 15 13 4
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[14] ^ s[12] ^ s[3];
    return {s[14:0], fb};
endfunction

// ====================
// Reference beat
// ====================
// Beat b of a packet of len bytes held in pkt_bytes, as {tdata, tkeep, tlast}
function automatic logic [72:0] expected_beat(input int len, input int b);
    logic [63:0] data;
    logic [7:0]  keep;
    int          n;
    int          i;
    n    = len - 8 * b;
    data = '0;
    keep = '0;
    // Lane 0 is the top byte, lanes past the end stay zero
    for (i = 0; i < 8; i++)
    begin
        if (i < n)
        begin
            data[63-8*i -: 8] = pkt_bytes[8*b+i];
            keep[7-i]         = 1'b1;
        end
    end
    return {data, keep, n <= 8};
endfunction

// Compare and stop at the first mismatch
task automatic check(input logic [127:0] got, input logic [127:0] exp, input string what);
    if (got !== exp)
    begin
        $display("ERROR at time %0t: %s, got %h expected %h", $time, what, got, exp);
        $display("RESULT: FAIL");
        $fatal(1);
    end
endtask

`endif

/* testbench/pb_tb.sv */
module pb_tb;

    logic                             clk;
    logic                             arst_n;
    logic                             reg_wr;
    logic                             reg_rd;
    logic [pb_pkg::reg_addr_wid-1:0]  reg_addr;
    logic [pb_pkg::reg_data_wid-1:0]  reg_wdata;
    logic [pb_pkg::reg_data_wid-1:0]  reg_rdata;
    logic                             reg_rvalid;
    logic                             axis_tvalid;
    logic                             axis_tready;
    logic [pb_pkg::data_wid-1:0]      axis_tdata;
    logic [pb_pkg::data_byte_wid-1:0] axis_tkeep;
    logic                             axis_tlast;
    logic [pb_pkg::tid_wid-1:0]       axis_tid;
    logic [pb_pkg::tdest_wid-1:0]     axis_tdest;
    logic [pb_pkg::tuser_wid-1:0]     axis_tuser;

    // Expected beats as {tid, tdest, tuser, tdata, tkeep, tlast}
    logic [124:0] exp_q [$];
    logic [7:0]   pkt_bytes [0:2047];
    // Separate LFSR streams for data and tready
    logic [15:0]  data_lfsr;
    logic [15:0]  ready_lfsr;
    int           words_loaded;
    int           cycle_cnt;
    logic         stalled;
    logic [124:0] held_beat;
    logic [124:0] cur_beat;
    logic [124:0] exp_beat;

    `include "pb_tb_model.svh"

    pb_top dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .reg_wr      (reg_wr),
        .reg_rd      (reg_rd),
        .reg_addr    (reg_addr),
        .reg_wdata   (reg_wdata),
        .reg_rdata   (reg_rdata),
        .reg_rvalid  (reg_rvalid),
        .axis_tvalid (axis_tvalid),
        .axis_tready (axis_tready),
        .axis_tdata  (axis_tdata),
        .axis_tkeep  (axis_tkeep),
        .axis_tlast  (axis_tlast),
        .axis_tid    (axis_tid),
        .axis_tdest  (axis_tdest),
        .axis_tuser  (axis_tuser)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ====================
    // Host side tasks
    // ====================
    // Inputs move 10 units after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic rand_bits(input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++)
        begin
            v         = {v[30:0], data_lfsr[15]};
            data_lfsr = lfsr_step(data_lfsr);
        end
    endtask

    task automatic reg_write(input logic [2:0] addr, input logic [31:0] data);
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        next_cycle();
        reg_wr = 1'b0;
    endtask

    task automatic reg_read(input logic [2:0] addr, output logic [31:0] data);
        reg_rd   = 1'b1;
        reg_addr = addr;
        next_cycle();
        reg_rd = 1'b0;
        // Read data is due exactly one cycle after the strobe
        check(reg_rvalid, 1'b1, "register read valid");
        data = reg_rdata;
    endtask

    // Low half first and the high half commits
    task automatic write_word(input logic [63:0] word);
        reg_write(pb_pkg::reg_wr_data_lo, word[31:0]);
        reg_write(pb_pkg::reg_wr_data_hi, word[63:32]);
        words_loaded++;
    endtask

    // Descriptor plus beats at the current write address
    task automatic load_packet(input int len);
        logic [31:0] r;
        logic [7:0]  tid;
        logic [11:0] tdest;
        logic [31:0] tuser;
        logic [63:0] word;
        int          nbeats;
        int          b;
        int          i;
        rand_bits(8, r);
        tid = r[7:0];
        rand_bits(12, r);
        tdest = r[11:0];
        rand_bits(32, r);
        tuser  = r;
        nbeats = (len + 7) / 8;
        // Filler past len is random too
        for (i = 0; i < nbeats * 8; i++)
        begin
            rand_bits(8, r);
            pkt_bytes[i] = r[7:0];
        end
        write_word({1'b0, 11'(len), tid, tdest, tuser});
        for (b = 0; b < nbeats; b++)
        begin
            for (i = 0; i < 8; i++)
            begin
                word[63-8*i -: 8] = pkt_bytes[8*b+i];
            end
            write_word(word);
            exp_q.push_back({tid, tdest, tuser, expected_beat(len, b)});
        end
    endtask

    // Start with enable set and wait for done and the last beat
    task automatic run_list(input int addr);
        logic [31:0] st;
        int          n;
        reg_write(pb_pkg::reg_pkt_addr, 32'(addr));
        reg_write(pb_pkg::reg_control, 32'h7);
        st = '0;
        while (!st[2])
        begin
            reg_read(pb_pkg::reg_status, st);
        end
        // At most two buffered beats remain after done
        n = 0;
        while ((exp_q.size() != 0) && (n < 64))
        begin
            next_cycle();
            n++;
        end
        if (exp_q.size() != 0)
        begin
            $display("%0d expected beats were never sent", exp_q.size());
            $display("RESULT: FAIL");
            $fatal(1);
        end
        else
        begin
            reg_read(pb_pkg::reg_status, st);
            check(st, 32'h5, "status after playback");
        end
    endtask

    // ====================
    // Test sequence
    // ====================
    initial
    begin
        logic [31:0] rd;
        logic [31:0] r;
        logic [31:0] r2;
        int          k;
        arst_n       = 1'b0;
        reg_wr       = 1'b0;
        reg_rd       = 1'b0;
        reg_addr     = '0;
        reg_wdata    = '0;
        axis_tready  = 1'b0;
        data_lfsr    = 16'd33;
        ready_lfsr   = 16'd33;
        words_loaded = 0;
        cycle_cnt    = 0;
        stalled      = 1'b0;
        held_beat    = '0;
        repeat (4) @(posedge clk);
        #10;
        arst_n = 1'b1;

        // Ready after the clear sweep and the info registers
        rd = '0;
        while (!rd[0])
        begin
            reg_read(pb_pkg::reg_status, rd);
        end
        check(rd, 32'h1, "status after clear");
        reg_read(pb_pkg::reg_info_mem_size, rd);
        check(rd, 32'd512, "memory size register");
        reg_read(pb_pkg::reg_info_meta_wid, rd);
        check(rd, 32'd52, "metadata width register");

        // Cleared memory from address 0 is a no-op
        run_list(0);

        // Explicit zero-length descriptor with metadata
        reg_write(pb_pkg::reg_wr_addr, 32'd400);
        rand_bits(20, r2);
        rand_bits(32, r);
        write_word({1'b0, 11'd0, r2[19:0], r});
        run_list(400);

        // Single 100-byte packet
        reg_write(pb_pkg::reg_wr_addr, 32'd0);
        load_packet(100);
        write_word(64'h0);
        run_list(0);

        // Start with enable low on the same list
        reg_write(pb_pkg::reg_control, 32'h4);
        reg_write(pb_pkg::reg_control, 32'h2);
        repeat (20) next_cycle();
        reg_read(pb_pkg::reg_status, rd);
        check(rd, 32'h1, "status after start with enable low");
        reg_read(pb_pkg::reg_control, rd);
        check(rd, 32'h0, "control after start with enable low");

        // Six packets back to back
        reg_write(pb_pkg::reg_wr_addr, 32'd32);
        for (k = 0; k < 6; k++)
        begin
            rand_bits(8, r);
            load_packet(1 + int'(r[7:0]) % 200);
        end
        write_word(64'h0);
        run_list(32);

        repeat (5) next_cycle();
        $display("RESULT: PASS");
        $finish;
    end

    // ====================
    // Stream side
    // ====================
    // One LFSR bit per cycle
    always @(posedge clk)
    begin
        #10;
        axis_tready = ready_lfsr[15];
        ready_lfsr  = lfsr_step(ready_lfsr);
    end

    // Sampled mid-cycle for the transfer at the next rising edge
    always @(negedge clk)
    begin
        if (arst_n)
        begin
            cur_beat = {axis_tid, axis_tdest, axis_tuser, axis_tdata, axis_tkeep, axis_tlast};
            if (stalled)
            begin
                check({axis_tvalid, cur_beat}, {1'b1, held_beat},
                      "stream held while stalled");
            end
            stalled   = axis_tvalid && !axis_tready;
            held_beat = cur_beat;
            if (axis_tvalid && axis_tready)
            begin
                if (exp_q.size() == 0)
                begin
                    $display("Unexpected stream beat at time %0t", $time);
                    $display("RESULT: FAIL");
                    $fatal(1);
                end
                else
                begin
                    exp_beat = exp_q.pop_front();
                    check(cur_beat, exp_beat, "stream beat");
                end
            end
        end
    end

    // Limit covers the clear sweep and four cycles per loaded word plus a margin
    always @(posedge clk)
    begin
        cycle_cnt++;
        if (cycle_cnt > 600 + 4 * words_loaded + 500)
        begin
            $display("Timeout after %0d cycles, the run did not finish", cycle_cnt);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    end

endmodule

/* verilog.f */
+incdir+include
design/pb_pkg.sv
design/pb_packet_mem.sv
design/pb_mem_arbiter.sv
design/pb_reg_block.sv
design/pb_playback_engine.sv
design/pb_top.sv
testbench/pb_tb.sv
